// File: include/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// Data and instruction word width
`define XLEN 32

// Architectural registers including r0
`define REG_NUM 16

// Instruction FIFO entries behind the APB slave
`define QUEUE_DEPTH 4

// Data memory words indexed by the low address bits
`define DMEM_WORDS 16

// APB register map
// Write pushes one instruction word
`define APB_ADDR_INSTR 32'h0000_0000
// Read returns queue occupancy
`define APB_ADDR_COUNT 32'h0000_0004

`endif

// File: src/pipe_pkg.sv
`include "pipe_settings.svh"

package pipe_pkg;

    // Register index sized from the register count
    typedef logic [$clog2(`REG_NUM)-1:0] reg_idx_t;

    // Opcodes in the top nibble of every instruction word
    // Values outside this list behave as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_LD   = 4'h6,
        OP_ST   = 4'h7
    } opcode_e;

    // Register format for ADD, SUB, AND, XOR
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        // Padding up to the full word
        logic [`XLEN-4-3*$clog2(`REG_NUM)-1:0] unused;
    } r_fmt_t;

    // Immediate format for ADDI, LD, ST
    // On ST the rd field names the data register
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        logic signed [`XLEN-4-2*$clog2(`REG_NUM)-1:0] imm;
    } i_fmt_t;

    // Same word seen in both layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

endpackage

// File: src/instr_queue.sv
`include "pipe_settings.svh"

module instr_queue (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                psel,
    input  wire                penable,
    input  wire                pwrite,
    input  wire  [`XLEN-1:0]   paddr,
    input  wire  [`XLEN-1:0]   pwdata,
    output logic [`XLEN-1:0]   prdata,
    output logic               pready,
    output logic               pslverr,
    input  wire                q_pop,
    output logic               q_valid,
    output logic [`XLEN-1:0]   q_instr
);
    localparam PTR_W = $clog2(`QUEUE_DEPTH);
    localparam CNT_W = $clog2(`QUEUE_DEPTH + 1);

    // Entry storage
    logic [`XLEN-1:0] fifo_mem [0:`QUEUE_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             access;
    logic             hit_instr;
    logic             hit_count;
    logic             full;
    logic             push;
    logic             pop;

    // Access phase of an APB transfer
    assign access    = psel & penable;
    assign hit_instr = (paddr == `APB_ADDR_INSTR);
    assign hit_count = (paddr == `APB_ADDR_COUNT);
    assign full      = (count == CNT_W'(`QUEUE_DEPTH));

    // Head is taken only while something is queued
    assign pop = q_pop & q_valid;

    // Back-pressure
    // A push into a full queue waits unless the head leaves this cycle
    assign pready = !(access & pwrite & hit_instr & full & !pop);

    // Unmapped address or a write to the read-only count register
    assign pslverr = access & (!(hit_instr | hit_count) | (hit_count & pwrite));

    assign push   = access & pwrite & hit_instr & pready;
    assign prdata = (access & !pwrite & hit_count) ? `XLEN'(count) : '0;

    // Head entry toward the pipeline
    assign q_valid = (count != '0);
    assign q_instr = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= pwdata;
        end
    end

    // Circular pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/reg_file.sv
`include "pipe_settings.svh"

module reg_file (
    input  wire                 clk,
    input  wire                 arst_n,
    input  pipe_pkg::reg_idx_t  rd_addr_a,
    input  pipe_pkg::reg_idx_t  rd_addr_b,
    output logic [`XLEN-1:0]    rd_data_a,
    output logic [`XLEN-1:0]    rd_data_b,
    input  wire                 wr_en,
    input  pipe_pkg::reg_idx_t  wr_addr,
    input  wire  [`XLEN-1:0]    wr_data
);
    // Register array with r0 writable like any other
    logic [`XLEN-1:0] regs [0:`REG_NUM-1];

    // Registers start from zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through
    // Decode reading the register that writeback writes now sees the new value
    // This closes the distance-three gap left by the bypass network
    always_comb begin
        if (wr_en && (wr_addr == rd_addr_a)) begin
            rd_data_a = wr_data;
        end else begin
            rd_data_a = regs[rd_addr_a];
        end
    end

    always_comb begin
        if (wr_en && (wr_addr == rd_addr_b)) begin
            rd_data_b = wr_data;
        end else begin
            rd_data_b = regs[rd_addr_b];
        end
    end

endmodule

// File: src/bypass_mux.sv
`include "pipe_settings.svh"

module bypass_mux (
    input  wire  [`XLEN-1:0]    file_out,
    input  pipe_pkg::reg_idx_t  file_out_rs,
    input  wire                 ex_w_en,
    input  pipe_pkg::reg_idx_t  ex_rd,
    input  wire  [`XLEN-1:0]    ex_pro,
    input  wire                 mm_w_en,
    input  pipe_pkg::reg_idx_t  mm_rd,
    input  wire  [`XLEN-1:0]    mm_pro,
    input  wire  [`XLEN-1:0]    mm_mem,
    input  wire                 mm_is_load,
    output logic [`XLEN-1:0]    bypass_out
);
    // Operand sources
    localparam logic [1:0] SEL_FILE = 2'b00;
    localparam logic [1:0] SEL_EX   = 2'b01;
    localparam logic [1:0] SEL_MM   = 2'b10;
    localparam logic [1:0] SEL_MEM  = 2'b11;

    logic [1:0] bypass_sel;

    // Priority
    // Youngest producer first, so execute beats memory
    always_comb begin
        if (ex_w_en && (file_out_rs == ex_rd)) begin
            bypass_sel = SEL_EX;
        end else if (mm_w_en && (file_out_rs == mm_rd)) begin
            // Loads forward the data memory output, not the address
            if (mm_is_load) begin
                bypass_sel = SEL_MEM;
            end else begin
                bypass_sel = SEL_MM;
            end
        end else begin
            bypass_sel = SEL_FILE;
        end
    end

    // Operand select
    always_comb begin
        case (bypass_sel)
            SEL_EX:  bypass_out = ex_pro;
            SEL_MM:  bypass_out = mm_pro;
            SEL_MEM: bypass_out = mm_mem;
            default: bypass_out = file_out;
        endcase
    end

endmodule

// File: src/mini_pipe.sv
`include "pipe_settings.svh"

module mini_pipe (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 q_valid,
    input  wire  [`XLEN-1:0]    q_instr,
    output logic                q_pop,
    output logic                wb_valid,
    output pipe_pkg::reg_idx_t  wb_rd,
    output logic [`XLEN-1:0]    wb_data
);
    localparam DMEM_AW = $clog2(`DMEM_WORDS);

    // Decode
    pipe_pkg::instr_u   dec;
    pipe_pkg::opcode_e  dec_op;
    pipe_pkg::reg_idx_t rs_a;
    pipe_pkg::reg_idx_t rs_b;
    logic               dec_is_r;
    logic               dec_wen;
    logic               dec_is_load;
    logic               dec_is_store;
    logic [`XLEN-1:0]   dec_imm;
    logic               stall;
    logic [`XLEN-1:0]   rf_a;
    logic [`XLEN-1:0]   rf_b;
    logic [`XLEN-1:0]   byp_a;
    logic [`XLEN-1:0]   byp_b;
    // Execute
    pipe_pkg::opcode_e  ex_op;
    pipe_pkg::reg_idx_t ex_rd;
    logic               ex_wen;
    logic               ex_is_load;
    logic               ex_is_store;
    logic [`XLEN-1:0]   ex_a;
    logic [`XLEN-1:0]   ex_b;
    logic [`XLEN-1:0]   ex_imm;
    logic [`XLEN-1:0]   ex_pro;
    // Memory
    pipe_pkg::reg_idx_t mm_rd;
    logic               mm_wen;
    logic               mm_is_load;
    logic               mm_is_store;
    logic [`XLEN-1:0]   mm_pro;
    logic [`XLEN-1:0]   mm_st_data;
    logic [`XLEN-1:0]   mm_mem;
    logic [`XLEN-1:0]   dmem [0:`DMEM_WORDS-1];

    // Head word seen through both formats
    assign dec    = q_instr;
    assign dec_op = dec.r_fmt.opcode;
    // Signed field sign-extends into the full word
    assign dec_imm = dec.i_fmt.imm;

    always_comb begin
        dec_is_r     = 1'b0;
        dec_wen      = 1'b0;
        dec_is_load  = 1'b0;
        dec_is_store = 1'b0;
        case (dec_op)
            pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_AND, pipe_pkg::OP_XOR: begin
                dec_is_r = 1'b1;
                dec_wen  = 1'b1;
            end
            pipe_pkg::OP_ADDI: dec_wen = 1'b1;
            pipe_pkg::OP_LD: begin
                dec_wen     = 1'b1;
                dec_is_load = 1'b1;
            end
            pipe_pkg::OP_ST: dec_is_store = 1'b1;
            // NOP and undefined opcodes do nothing
            default: dec_wen = 1'b0;
        endcase
    end

    // Port A always rs1, port B is rs2 or the store data register
    assign rs_a = dec.r_fmt.rs1;
    assign rs_b = dec_is_store ? dec.i_fmt.rd : dec.r_fmt.rs2;

    // Load-use hazard
    // Loaded data exists only in memory stage, so hold the head one cycle
    assign stall = ex_is_load & (((dec_wen | dec_is_store) & (rs_a == ex_rd)) |
                                 ((dec_is_r | dec_is_store) & (rs_b == ex_rd)));
    assign q_pop = q_valid & !stall;

    reg_file reg_file_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rs_a),
        .rd_addr_b (rs_b),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (wb_valid),
        .wr_addr   (wb_rd),
        .wr_data   (wb_data)
    );

    // One mux per source operand
    // Loads in execute are masked out since the stall already covers them
    bypass_mux bypass_a_inst (
        .file_out    (rf_a),
        .file_out_rs (rs_a),
        .ex_w_en     (ex_wen & !ex_is_load),
        .ex_rd       (ex_rd),
        .ex_pro      (ex_pro),
        .mm_w_en     (mm_wen),
        .mm_rd       (mm_rd),
        .mm_pro      (mm_pro),
        .mm_mem      (mm_mem),
        .mm_is_load  (mm_is_load),
        .bypass_out  (byp_a)
    );

    bypass_mux bypass_b_inst (
        .file_out    (rf_b),
        .file_out_rs (rs_b),
        .ex_w_en     (ex_wen & !ex_is_load),
        .ex_rd       (ex_rd),
        .ex_pro      (ex_pro),
        .mm_w_en     (mm_wen),
        .mm_rd       (mm_rd),
        .mm_pro      (mm_pro),
        .mm_mem      (mm_mem),
        .mm_is_load  (mm_is_load),
        .bypass_out  (byp_b)
    );

    // Stage control lets bubbles enter execute when nothing is popped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_wen      <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
            ex_rd       <= '0;
            mm_wen      <= 1'b0;
            mm_is_load  <= 1'b0;
            mm_is_store <= 1'b0;
            mm_rd       <= '0;
            wb_valid    <= 1'b0;
        end else begin
            ex_wen      <= q_pop & dec_wen;
            ex_is_load  <= q_pop & dec_is_load;
            ex_is_store <= q_pop & dec_is_store;
            ex_rd       <= dec.r_fmt.rd;
            mm_wen      <= ex_wen;
            mm_is_load  <= ex_is_load;
            mm_is_store <= ex_is_store;
            mm_rd       <= ex_rd;
            wb_valid    <= mm_wen;
        end
    end

    // Stage payload
    always_ff @(posedge clk) begin
        ex_op      <= dec_op;
        ex_a       <= byp_a;
        ex_b       <= byp_b;
        ex_imm     <= dec_imm;
        mm_pro     <= ex_pro;
        mm_st_data <= ex_b;
        wb_rd      <= mm_rd;
        wb_data    <= mm_is_load ? mm_mem : mm_pro;
    end

    // ALU also forms LD and ST effective addresses
    always_comb begin
        case (ex_op)
            pipe_pkg::OP_ADD:  ex_pro = ex_a + ex_b;
            pipe_pkg::OP_SUB:  ex_pro = ex_a - ex_b;
            pipe_pkg::OP_AND:  ex_pro = ex_a & ex_b;
            pipe_pkg::OP_XOR:  ex_pro = ex_a ^ ex_b;
            pipe_pkg::OP_ADDI, pipe_pkg::OP_LD, pipe_pkg::OP_ST: ex_pro = ex_a + ex_imm;
            default:           ex_pro = '0;
        endcase
    end

    // Data memory address wraps on the low bits
    assign mm_mem = dmem[mm_pro[DMEM_AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mm_is_store) begin
            dmem[mm_pro[DMEM_AW-1:0]] <= mm_st_data;
        end
    end

endmodule

// File: src/pipe_top.sv
`include "pipe_settings.svh"

module pipe_top (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire  [`XLEN-1:0]    paddr,
    input  wire  [`XLEN-1:0]    pwdata,
    output logic [`XLEN-1:0]    prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                wb_valid,
    output pipe_pkg::reg_idx_t  wb_rd,
    output logic [`XLEN-1:0]    wb_data
);
    // Queue head handshake
    logic             q_valid;
    logic             q_pop;
    logic [`XLEN-1:0] q_instr;

    // APB slave and instruction buffer
    instr_queue instr_queue_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .q_pop   (q_pop),
        .q_valid (q_valid),
        .q_instr (q_instr)
    );

    // Pipeline drains the queue, writeback shows on the trace ports
    mini_pipe mini_pipe_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .q_valid  (q_valid),
        .q_instr  (q_instr),
        .q_pop    (q_pop),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// File: verif/pipe_asserts.sv
module pipe_asserts (
    input wire clk,
    input wire arst_n,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr,
    input wire wb_valid,
    input wire q_valid,
    input wire q_pop,
    input wire q_full
);
    // Back-pressure only ever comes from a full queue
    pready_when_room: assert property (
        @(posedge clk) disable iff (!arst_n) !q_full |-> pready
    ) else $error("pready low while the queue has free entries");

    // Slave error belongs to the access phase
    pslverr_in_access: assert property (
        @(posedge clk) disable iff (!arst_n) pslverr |-> (psel && penable)
    ) else $error("pslverr raised outside the APB access phase");

    // No writeback straight out of reset
    wb_quiet_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !wb_valid
    ) else $error("wb_valid high in the first cycle after reset release");

    // Pipeline takes the head only when one exists
    pop_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) q_pop |-> q_valid
    ) else $error("q_pop high while the queue is empty");

endmodule

// File: verif/pipe_tb.sv
`include "pipe_settings.svh"

module pipe_tb;
    localparam int DMEM_AW    = $clog2(`DMEM_WORDS);
    // Instruction counts per test group set the run limit
    localparam int N_RESET    = 1;
    localparam int N_INDEP    = 8;
    localparam int N_FWD      = 4;
    localparam int N_RANDOM   = 200;
    localparam int N_MEM      = 10;
    localparam int N_BURST    = `QUEUE_DEPTH + 3;
    localparam int N_TOTAL    = N_RESET + N_INDEP + N_FWD + N_RANDOM + N_MEM + N_BURST;
    localparam int MAX_CYCLES = 20 * N_TOTAL + 200;

    typedef struct packed {
        logic [3:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_exp_t;

    logic               clk;
    logic               arst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`XLEN-1:0]   paddr;
    logic [`XLEN-1:0]   pwdata;
    logic [`XLEN-1:0]   prdata;
    logic               pready;
    logic               pslverr;
    logic               wb_valid;
    pipe_pkg::reg_idx_t wb_rd;
    logic [`XLEN-1:0]   wb_data;

    // Model state and expected writebacks in program order
    logic [`XLEN-1:0]   model_regs [0:`REG_NUM-1];
    logic [`XLEN-1:0]   model_mem [0:`DMEM_WORDS-1];
    wb_exp_t            exp_q [$];
    logic [31:0]        lcg_state = 32'h1394;
    int                 cycles = 0;

    pipe_top pipe_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    bind pipe_top pipe_asserts pipe_asserts_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .psel     (psel),
        .penable  (penable),
        .pready   (pready),
        .pslverr  (pslverr),
        .wb_valid (wb_valid),
        .q_valid  (q_valid),
        .q_pop    (q_pop),
        .q_full   (instr_queue_inst.full)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        assert (cycles < MAX_CYCLES) else
            stop_on_error($sformatf("Timeout: the run hung, still busy after %0d cycles", cycles));
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2, 16'h0000};
    endfunction

    function automatic logic [31:0] enc_i(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [19:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // Sequential reference executing one instruction at a time
    // Returns 1 when the instruction writes a register
    function automatic logic ref_exec(input logic [31:0] w, output logic [3:0] rd,
                                      output logic [`XLEN-1:0] data);
        logic [3:0]       op;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] addr;
        logic             writes;
        op     = w[31:28];
        rd     = w[27:24];
        a      = model_regs[w[23:20]];
        b      = model_regs[w[19:16]];
        // 20-bit signed immediate
        imm    = {{12{w[19]}}, w[19:0]};
        addr   = a + imm;
        data   = '0;
        writes = 1'b1;
        case (op)
            pipe_pkg::OP_ADD:  data = a + b;
            pipe_pkg::OP_SUB:  data = a - b;
            pipe_pkg::OP_AND:  data = a & b;
            pipe_pkg::OP_XOR:  data = a ^ b;
            pipe_pkg::OP_ADDI: data = addr;
            pipe_pkg::OP_LD:   data = model_mem[addr[DMEM_AW-1:0]];
            pipe_pkg::OP_ST: begin
                // Store data comes from the rd field
                model_mem[addr[DMEM_AW-1:0]] = model_regs[rd];
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            model_regs[rd] = data;
        end
        return writes;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [3:0]  op;
        r = lcg_next();
        s = lcg_next();
        case ((r >> 24) % 7)
            0:       op = pipe_pkg::OP_ADD;
            1:       op = pipe_pkg::OP_SUB;
            2:       op = pipe_pkg::OP_AND;
            3:       op = pipe_pkg::OP_XOR;
            4:       op = pipe_pkg::OP_ADDI;
            5:       op = pipe_pkg::OP_LD;
            default: op = pipe_pkg::OP_ST;
        endcase
        // Only r0..r3, so dependencies are frequent
        if (op == pipe_pkg::OP_ADDI || op == pipe_pkg::OP_LD || op == pipe_pkg::OP_ST) begin
            return enc_i(op, {2'b00, r[1:0]}, {2'b00, r[3:2]}, s[19:0]);
        end
        return enc_r(op, {2'b00, r[1:0]}, {2'b00, r[3:2]}, {2'b00, r[5:4]});
    endfunction

    // APB master tasks enter and leave 2 units after a rising edge
    task automatic apb_write(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        err = pslverr;
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [`XLEN-1:0] addr, output logic [`XLEN-1:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    // Model first, then push the word into the DUT queue
    task automatic issue(input logic [31:0] word);
        logic             err;
        logic             writes;
        logic [3:0]       rd;
        logic [`XLEN-1:0] data;
        writes = ref_exec(word, rd, data);
        if (writes) begin
            exp_q.push_back('{rd: rd, data: data});
        end
        apb_write(`APB_ADDR_INSTR, word, err);
        assert (!err) else
            stop_on_error($sformatf("[FAIL] %0t instruction push %h got pslverr", $time, word));
    endtask

    task automatic read_count(output int count);
        logic [`XLEN-1:0] data;
        logic             err;
        apb_read(`APB_ADDR_COUNT, data, err);
        count = int'(data);
        assert (!err && count <= `QUEUE_DEPTH) else
            stop_on_error($sformatf("[FAIL] %0t count read %0d err %0b", $time, data, err));
    endtask

    // Expectations drained, then a few cycles so trailing stores land
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    // Compare each writeback with the oldest expectation
    always @(negedge clk) begin : compare_wb
        wb_exp_t exp;
        if (arst_n && wb_valid) begin
            assert (exp_q.size() != 0) else
                stop_on_error($sformatf("Unexpected writeback to r%0d at time %0t", wb_rd, $time));
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                assert (wb_rd == exp.rd && wb_data == exp.data) else
                    stop_on_error($sformatf("[FAIL] %0t expected r%0d=%h, got r%0d=%h",
                                            $time, exp.rd, exp.data, wb_rd, wb_data));
            end
        end
    end

    initial begin : stimulus
        int               count;
        logic             err;
        logic [`XLEN-1:0] rdata;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        arst_n  = 1'b0;
        for (int i = 0; i < `REG_NUM; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;

        // Empty queue after reset, no writeback, r0 reads zero
        read_count(count);
        assert (count == 0) else
            stop_on_error($sformatf("[FAIL] %0t count after reset is %0d", $time, count));
        repeat (5) @(posedge clk);
        #2;
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd1, 4'd0, 20'd0));
        wait_drain();

        // Operands first, then independent ALU ops
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd1, 4'd0, 20'd5));
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd2, 4'd0, -20'd3));
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd3, 4'd0, 20'h0007f));
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd4, 4'd0, 20'h01234));
        wait_drain();
        issue(enc_r(pipe_pkg::OP_ADD, 4'd5, 4'd1, 4'd2));
        issue(enc_r(pipe_pkg::OP_SUB, 4'd6, 4'd3, 4'd4));
        issue(enc_r(pipe_pkg::OP_AND, 4'd7, 4'd3, 4'd4));
        issue(enc_r(pipe_pkg::OP_XOR, 4'd8, 4'd1, 4'd4));
        wait_drain();

        // Consumers of r9 at distance one, two and three
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd9, 4'd0, 20'd11));
        issue(enc_r(pipe_pkg::OP_ADD, 4'd10, 4'd9, 4'd9));
        issue(enc_r(pipe_pkg::OP_ADD, 4'd11, 4'd9, 4'd1));
        issue(enc_r(pipe_pkg::OP_SUB, 4'd12, 4'd1, 4'd9));
        wait_drain();

        for (int i = 0; i < N_RANDOM; i++) begin
            issue(random_instr());
        end
        wait_drain();

        // Store, load, and an immediate consumer of the load
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd1, 4'd0, 20'h00055));
        issue(enc_i(pipe_pkg::OP_ST, 4'd1, 4'd0, 20'd3));
        issue(enc_i(pipe_pkg::OP_LD, 4'd2, 4'd0, 20'd3));
        issue(enc_r(pipe_pkg::OP_ADD, 4'd3, 4'd2, 4'd2));
        // Addresses that wrap to word 0
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd4, 4'd0, 20'd20));
        issue(enc_i(pipe_pkg::OP_ADDI, 4'd5, 4'd0, -20'd1));
        issue(enc_i(pipe_pkg::OP_ST, 4'd4, 4'd5, 20'd1));
        issue(enc_i(pipe_pkg::OP_LD, 4'd6, 4'd0, 20'd16));
        issue(enc_r(pipe_pkg::OP_XOR, 4'd7, 4'd6, 4'd4));
        issue(enc_i(pipe_pkg::OP_LD, 4'd8, 4'd0, -20'd16));
        wait_drain();

        // Back-to-back burst past the queue depth
        for (int i = 0; i < N_BURST; i++) begin
            issue(enc_i(pipe_pkg::OP_ADDI, 4'(i), 4'd0, 20'(i * 7 + 1)));
        end
        read_count(count);
        wait_drain();
        read_count(count);
        assert (count == 0) else
            stop_on_error($sformatf("[FAIL] %0t count after drain is %0d", $time, count));

        // None of the error responses may reach writeback
        apb_write(32'h0000_0008, enc_i(pipe_pkg::OP_ADDI, 4'd1, 4'd0, 20'd9), err);
        assert (err) else
            stop_on_error($sformatf("[FAIL] %0t unmapped write without pslverr", $time));
        apb_write(`APB_ADDR_COUNT, enc_i(pipe_pkg::OP_ADDI, 4'd2, 4'd0, 20'd9), err);
        assert (err) else
            stop_on_error($sformatf("[FAIL] %0t count write without pslverr", $time));
        apb_read(32'h0000_000C, rdata, err);
        assert (err) else
            stop_on_error($sformatf("[FAIL] %0t unmapped read without pslverr", $time));
        repeat (8) @(posedge clk);
        #2;

        if (exp_q.size() != 0) begin
            stop_on_error($sformatf("%0d expected writebacks never appeared", exp_q.size()));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+include
src/pipe_pkg.sv
src/instr_queue.sv
src/reg_file.sv
src/bypass_mux.sv
src/mini_pipe.sv
src/pipe_top.sv
verif/pipe_asserts.sv
verif/pipe_tb.sv

// File: Makefile
TOP  := pipe_tb
SRCS := $(wildcard include/*.svh src/*.sv verif/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
